/* tb.f */
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch_port.sv
hdl/branch_decode.sv
hdl/branch_regfile.sv
hdl/pc_unit.sv
hdl/front_end_top.sv
tests/tb_clock.sv
tests/front_end_tb.sv

/* Bender.yml */
package:
  name: front_end

sources:
  - files:
      - hdl/isa_pkg.sv
      - hdl/fetch_pkg.sv
      - hdl/fetch_port.sv
      - hdl/branch_decode.sv
      - hdl/branch_regfile.sv
      - hdl/pc_unit.sv
      - hdl/front_end_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/front_end_tb.sv

/* tests/front_end_tb.sv */
`timescale 1ns/1ps

module front_end_tb;

	localparam int RESET_PC = 0;
	localparam int DONE_TIMEOUT = 60;
	localparam logic [5:0] OP_B  = 6'b100110;
	localparam logic [5:0] OP_J  = 6'b100100;
	localparam logic [5:0] OP_JR = 6'b100101;
	localparam logic [31:0] NOP = 32'h0010_0400;

	logic        clock;
	logic        reset;
	logic        hazard;
	logic        imem_req;
	logic [9:0]  imem_addr;
	logic        imem_ack;
	logic [31:0] imem_rdata;
	logic        wr_en;
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;
	logic [9:0]  pc;
	logic        redirect;
	logic        link_req;
	logic [9:0]  link_value;
	logic        fetch_done;

	logic [31:0] mem [256];
	logic [31:0] shadow [32];
	logic [9:0]  model_pc;
	integer      seed = 8;
	int          error_count = 0;
	int          timeout_count = 0;
	logic        req_prev = 1'b0;
	logic        ack_prev = 1'b0;

	tb_clock #(.PERIOD(100), .RESET_CYCLES(4)) clock_gen (.clock(clock), .reset(reset));

	front_end_top #(.PC_WIDTH(10), .RESET_PC(RESET_PC)) UUT (
		.clock(clock), .reset(reset), .hazard(hazard),
		.imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
		.imem_rdata(imem_rdata), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.pc(pc), .redirect(redirect), .link_req(link_req), .link_value(link_value),
		.fetch_done(fetch_done)
	);

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// Behavioral instruction memory with random ack delays.
	initial begin
		int delay;
		bit released;
		imem_ack = 1'b0;
		imem_rdata = '0;
		forever begin
			@(negedge clock);
			if (imem_req && !imem_ack) begin
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(negedge clock);
				imem_rdata = mem[imem_addr[9:2]];
				imem_ack = 1'b1;
				released = 1'b0;
				for (int n = 0; n < 20 && !released; n++) begin
					@(negedge clock);
					released = !imem_req;
				end
				if (!released) begin
					$display("Timeout: memory never saw the request drop");
					timeout_count++;
				end
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(negedge clock);
				imem_ack = 1'b0;
			end
		end
	end

	// Handshake monitor on values settled before each rising edge.
	always @(posedge clock) begin
		if (!reset) begin
			if (imem_req && !req_prev && ack_prev) begin
				error_count++;
				$display("Request raised at %0t ns while acknowledge was still high", $time);
			end
			if (imem_req) begin
				check("imem_addr", imem_addr, model_pc);
			end
		end
		req_prev <= imem_req;
		ack_prev <= imem_ack;
	end

	function automatic logic [31:0] enc_branch(input bit bne, input logic [4:0] ra,
			input logic [4:0] rt, input logic [8:0] off);
		return {1'b0, OP_B, rt, ra, bne, off[8], 5'b0, off[7:0]};
	endfunction

	function automatic logic [31:0] enc_jump(input bit jal, input logic [8:0] off);
		return {1'b0, OP_J, jal, off[8], 15'b0, off[7:0]};
	endfunction

	function automatic logic [31:0] enc_jr(input logic [4:0] rb);
		return {1'b0, OP_JR, 10'b0, rb, 10'b0};
	endfunction

	// Next PC from the instruction word and the shadow registers.
	task automatic predict(input logic [9:0] cur, input logic [31:0] w,
			output logic [9:0] nxt, output bit redir, output bit link);
		logic [9:0] off;
		logic eq;
		nxt = cur + 10'd4;
		redir = 1'b0;
		link = 1'b0;
		case (w[30:25])
			OP_B: begin
				eq = (shadow[w[19:15]] == shadow[w[24:20]]);
				if (w[14] ? !eq : eq) begin
					off = {w[13], w[7:0], 1'b0};
					nxt = cur + off;
					redir = 1'b1;
				end
			end
			OP_J: begin
				off = {w[23], w[7:0], 1'b0};
				nxt = cur + off;
				redir = 1'b1;
				link = w[24];
			end
			OP_JR: begin
				nxt = shadow[w[14:10]][9:0];
				redir = 1'b1;
			end
			default: ;
		endcase
	endtask

	task automatic wait_fetch_done(output bit ok);
		ok = 1'b0;
		for (int i = 0; i < DONE_TIMEOUT && !ok; i++) begin
			@(negedge clock);
			ok = fetch_done;
		end
		if (!ok) begin
			$display("Timeout: no fetch completed at %0t ns", $time);
			timeout_count++;
		end
	endtask

	task automatic wait_request(output bit ok);
		ok = 1'b0;
		for (int i = 0; i < DONE_TIMEOUT && !ok; i++) begin
			@(negedge clock);
			ok = imem_req;
		end
		if (!ok) begin
			$display("Timeout: no instruction request at %0t ns", $time);
			timeout_count++;
		end
	endtask

	task automatic preload(input logic [4:0] addr, input logic [31:0] data);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		shadow[addr] = data;
		@(negedge clock);
		wr_en = 1'b0;
	endtask

	// Completes the fetch in flight, checks it and places the next word.
	task automatic step(input logic [31:0] next_word);
		logic [9:0] exp_pc;
		bit exp_redir;
		bit exp_link;
		bit ok;
		predict(model_pc, mem[model_pc[9:2]], exp_pc, exp_redir, exp_link);
		wait_fetch_done(ok);
		if (ok) begin
			check("redirect", redirect, exp_redir);
			check("link_req", link_req, exp_link);
			if (exp_link) begin
				check("link_value", link_value, model_pc + 10'd4);
				shadow[30] = {22'd0, model_pc + 10'd4};
			end
			@(posedge clock);
			@(negedge clock);
			check("pc", pc, exp_pc);
			check("fetch_done", fetch_done, 0);
		end
		model_pc = exp_pc;
		mem[model_pc[9:2]] = next_word;
	endtask

	task automatic reset_and_sequence();
		bit ok;
		repeat (2) @(negedge clock);
		check("pc", pc, RESET_PC);
		check("imem_req", imem_req, 0);
		check("fetch_done", fetch_done, 0);
		check("redirect", redirect, 0);
		check("link_req", link_req, 0);
		ok = 1'b0;
		for (int i = 0; i < 20 && !ok; i++) begin
			@(negedge clock);
			ok = !reset;
		end
		if (!ok) begin
			$display("Timeout: reset never released");
			timeout_count++;
		end
		repeat (4) step(NOP);
	endtask

	task automatic conditional_branches();
		preload(5'd1, 32'h55);
		preload(5'd2, 32'h55);
		step(enc_branch(1'b0, 5'd1, 5'd2, 9'h010));
		preload(5'd3, 32'h77);
		step(enc_branch(1'b0, 5'd1, 5'd3, 9'h010));
		step(enc_branch(1'b1, 5'd1, 5'd3, 9'h1F0));
		step(enc_branch(1'b1, 5'd1, 5'd2, 9'h008));
		step(NOP);
	endtask

	task automatic jump_and_link();
		step(enc_jump(1'b1, 9'h020));
		step(enc_jr(5'd30));
		step(enc_jump(1'b0, 9'h1E0));
		step(NOP);
	endtask

	task automatic jump_through_register();
		preload(5'd5, 32'hABCD_0124);
		step(enc_jr(5'd5));
		step(NOP);
	endtask

	task automatic hazard_replay();
		logic [9:0] held_pc;
		bit ok;
		step(enc_jump(1'b0, 9'h004));
		held_pc = model_pc;
		wait_request(ok);
		hazard = 1'b1;
		wait_fetch_done(ok);
		check("redirect", redirect, 0);
		check("link_req", link_req, 0);
		@(posedge clock);
		@(negedge clock);
		check("pc", pc, held_pc);
		repeat (3) begin
			@(negedge clock);
			check("imem_req", imem_req, 0);
		end
		hazard = 1'b0;
		wait_request(ok);
		check("imem_addr", imem_addr, held_pc);
		step(NOP);
		step(NOP);
	endtask

	initial begin
		hazard = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		model_pc = RESET_PC;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'h00a5_0000 | 32'(i);
		end
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		reset_and_sequence();
		conditional_branches();
		jump_and_link();
		jump_through_register();
		hazard_replay();
		$display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		#2_000_000;
		$display("Simulation time limit reached");
		$display("Finished with errors");
		$finish;
	end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// Reset drops on a falling edge.
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset <= 1'b0;
	end

endmodule

/* hdl/front_end_top.sv */
`timescale 1ns/1ps

module front_end_top #(
	parameter int PC_WIDTH = fetch_pkg::PC_WIDTH,
	parameter int RESET_PC = 0
) (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                hazard,
	output logic                                imem_req,
	output logic [PC_WIDTH-1:0]                 imem_addr,
	input  logic                                imem_ack,
	input  logic [31:0]                         imem_rdata,
	input  logic                                wr_en,
	input  logic [fetch_pkg::REG_ADDR_WIDTH-1:0] wr_addr,
	input  logic [31:0]                         wr_data,
	output logic [PC_WIDTH-1:0]                 pc,
	output logic                                redirect,
	output logic                                link_req,
	output logic [PC_WIDTH-1:0]                 link_value,
	output logic                                fetch_done
);

	import isa_pkg::*;
	import fetch_pkg::*;

	logic [31:0]               instr;
	opcode_t                   opcode;
	sub_b_t                    sub_b;
	sub_j_t                    sub_j;
	logic [13:0]               imm14;
	logic [23:0]               imm24;
	logic [REG_ADDR_WIDTH-1:0] ra_idx;
	logic [REG_ADDR_WIDTH-1:0] rt_idx;
	logic [REG_ADDR_WIDTH-1:0] rb_idx;
	logic [31:0]               rb_data;
	logic                      rt_ra_equal;

	fetch_port #(
		.PC_WIDTH(PC_WIDTH)
	) u_fetch_port (
		.clock      (clock),
		.reset      (reset),
		.pc         (pc),
		.hazard     (hazard),
		.imem_req   (imem_req),
		.imem_addr  (imem_addr),
		.imem_ack   (imem_ack),
		.imem_rdata (imem_rdata),
		.instr      (instr),
		.fetch_done (fetch_done)
	);

	branch_decode u_branch_decode (
		.instr  (instr),
		.opcode (opcode),
		.sub_b  (sub_b),
		.sub_j  (sub_j),
		.imm14  (imm14),
		.imm24  (imm24),
		.ra_idx (ra_idx),
		.rt_idx (rt_idx),
		.rb_idx (rb_idx)
	);

	// The return address is zero extended into a full register word.
	branch_regfile u_branch_regfile (
		.clock       (clock),
		.reset       (reset),
		.ra_idx      (ra_idx),
		.rt_idx      (rt_idx),
		.rb_idx      (rb_idx),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.link_req    (link_req),
		.link_value  (32'(link_value)),
		.rb_data     (rb_data),
		.rt_ra_equal (rt_ra_equal)
	);

	pc_unit #(
		.PC_WIDTH(PC_WIDTH),
		.RESET_PC(RESET_PC)
	) u_pc_unit (
		.clock       (clock),
		.reset       (reset),
		.fetch_done  (fetch_done),
		.hazard      (hazard),
		.opcode      (opcode),
		.sub_b       (sub_b),
		.sub_j       (sub_j),
		.rt_ra_equal (rt_ra_equal),
		.imm14       (imm14),
		.imm24       (imm24),
		.rb_data     (rb_data),
		.pc          (pc),
		.redirect    (redirect),
		.link_req    (link_req),
		.link_value  (link_value)
	);

endmodule

/* hdl/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit #(
	parameter int PC_WIDTH = fetch_pkg::PC_WIDTH,
	parameter int RESET_PC = 0
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 fetch_done,
	input  logic                 hazard,
	input  isa_pkg::opcode_t     opcode,
	input  isa_pkg::sub_b_t      sub_b,
	input  isa_pkg::sub_j_t      sub_j,
	input  logic                 rt_ra_equal,
	input  logic [13:0]          imm14,
	input  logic [23:0]          imm24,
	input  logic [31:0]          rb_data,
	output logic [PC_WIDTH-1:0]  pc,
	output logic                 redirect,
	output logic                 link_req,
	output logic [PC_WIDTH-1:0]  link_value
);

	import isa_pkg::*;
	import fetch_pkg::*;

	pc_sel_t             pc_sel;
	logic                is_jal;
	logic                advance;
	logic [9:0]          off14;
	logic [9:0]          off24;
	logic [PC_WIDTH-1:0] pc_plus4;
	logic [PC_WIDTH-1:0] next_pc;

	// The PC only moves when a fetch completes outside a hazard.
	assign advance = fetch_done && !hazard;

	assign pc_plus4 = pc + PC_WIDTH'(4);

	// Short offsets keep the sign bit and the low byte of the immediate.
	assign off14 = {imm14[13], imm14[7:0], 1'b0};
	assign off24 = {imm24[23], imm24[7:0], 1'b0};

	always_comb begin
		pc_sel = pc_seq;
		is_jal = 1'b0;
		case (opcode)
			ty_b: begin
				if ((sub_b == beq) && rt_ra_equal) begin
					pc_sel = pc_imm14;
				end else if ((sub_b == bne) && !rt_ra_equal) begin
					pc_sel = pc_imm14;
				end
			end
			ty_j: begin
				pc_sel = pc_imm24;
				is_jal = (sub_j == jal);
			end
			op_jr: begin
				pc_sel = pc_reg;
			end
			default: begin
				pc_sel = pc_seq;
			end
		endcase
	end

	always_comb begin
		case (pc_sel)
			pc_imm14: next_pc = pc + PC_WIDTH'($signed(off14));
			pc_imm24: next_pc = pc + PC_WIDTH'($signed(off24));
			pc_reg:   next_pc = rb_data[PC_WIDTH-1:0];
			default:  next_pc = pc_plus4;
		endcase
	end

	// Valid in the fetch_done cycle, so the link write lands once.
	assign redirect   = advance && (pc_sel != pc_seq);
	assign link_req   = advance && is_jal;
	assign link_value = pc_plus4;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= PC_WIDTH'(RESET_PC);
		end else if (advance) begin
			pc <= next_pc;
		end
	end

endmodule

/* hdl/branch_regfile.sv */
`timescale 1ns/1ps

module branch_regfile (
	input  logic                                clock,
	input  logic                                reset,
	input  logic [fetch_pkg::REG_ADDR_WIDTH-1:0] ra_idx,
	input  logic [fetch_pkg::REG_ADDR_WIDTH-1:0] rt_idx,
	input  logic [fetch_pkg::REG_ADDR_WIDTH-1:0] rb_idx,
	input  logic                                wr_en,
	input  logic [fetch_pkg::REG_ADDR_WIDTH-1:0] wr_addr,
	input  logic [31:0]                         wr_data,
	input  logic                                link_req,
	input  logic [31:0]                         link_value,
	output logic [31:0]                         rb_data,
	output logic                                rt_ra_equal
);

	import isa_pkg::*;

	logic [31:0] regs [32];
	logic [31:0] ra_data;
	logic [31:0] rt_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wr_en) begin
				regs[wr_addr] <= wr_data;
			end
			// Later assignment wins, so the link write overrides a preload.
			if (link_req) begin
				regs[link_reg] <= link_value;
			end
		end
	end

	// Register 0 is hardwired to zero.
	assign ra_data = (ra_idx == '0) ? 32'd0 : regs[ra_idx];
	assign rt_data = (rt_idx == '0) ? 32'd0 : regs[rt_idx];
	assign rb_data = (rb_idx == '0) ? 32'd0 : regs[rb_idx];

	assign rt_ra_equal = (ra_data == rt_data);

endmodule

/* hdl/branch_decode.sv */
`timescale 1ns/1ps

module branch_decode (
	input  logic [31:0]                         instr,
	output isa_pkg::opcode_t                    opcode,
	output isa_pkg::sub_b_t                     sub_b,
	output isa_pkg::sub_j_t                     sub_j,
	output logic [13:0]                         imm14,
	output logic [23:0]                         imm24,
	output logic [fetch_pkg::REG_ADDR_WIDTH-1:0] ra_idx,
	output logic [fetch_pkg::REG_ADDR_WIDTH-1:0] rt_idx,
	output logic [fetch_pkg::REG_ADDR_WIDTH-1:0] rb_idx
);

	import isa_pkg::*;

	logic [5:0] op_bits;

	assign op_bits = instr[OPCODE_HI:OPCODE_LO];

	// Anything unrecognised falls through as a plain sequential op.
	always_comb begin
		case (op_bits)
			ty_b:    opcode = ty_b;
			ty_j:    opcode = ty_j;
			op_jr:   opcode = op_jr;
			default: opcode = op_other;
		endcase
	end

	assign sub_b = sub_b_t'(instr[SUB_B_BIT]);
	assign sub_j = sub_j_t'(instr[SUB_J_BIT]);

	assign imm14 = instr[IMM14_HI:IMM14_LO];
	assign imm24 = instr[IMM24_HI:IMM24_LO];

	assign rt_idx = instr[RT_HI:RT_LO];
	assign ra_idx = instr[RA_HI:RA_LO];
	assign rb_idx = instr[RB_HI:RB_LO];

endmodule

/* hdl/fetch_port.sv */
`timescale 1ns/1ps

module fetch_port #(
	parameter int PC_WIDTH = fetch_pkg::PC_WIDTH
) (
	input  logic                clock,
	input  logic                reset,
	input  logic [PC_WIDTH-1:0] pc,
	input  logic                hazard,
	output logic                imem_req,
	output logic [PC_WIDTH-1:0] imem_addr,
	input  logic                imem_ack,
	input  logic [31:0]         imem_rdata,
	output logic [31:0]         instr,
	output logic                fetch_done
);

	typedef enum logic [1:0] {
		idle,
		wait_ack,
		wait_release,
		done
	} state_t;

	state_t state;

	// One cycle pulse after the memory has released ack.
	assign fetch_done = (state == done);

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= idle;
			imem_req  <= 1'b0;
			imem_addr <= '0;
			instr     <= '0;
		end else begin
			case (state)
				idle: begin
					// Hold off while the pipeline is stalled.
					if (!hazard) begin
						imem_req  <= 1'b1;
						imem_addr <= pc;
						state     <= wait_ack;
					end
				end
				wait_ack: begin
					if (imem_ack) begin
						instr    <= imem_rdata;
						imem_req <= 1'b0;
						state    <= wait_release;
					end
				end
				wait_release: begin
					if (!imem_ack) begin
						state <= done;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

/* hdl/fetch_pkg.sv */
package fetch_pkg;

	// Source of the next program counter.
	typedef enum logic [1:0] {
		pc_seq   = 2'd0,
		pc_imm14 = 2'd1,
		pc_imm24 = 2'd2,
		pc_reg   = 2'd3
	} pc_sel_t;

	// PC and instruction memory address width.
	localparam int PC_WIDTH = 10;

	// Register index width.
	localparam int REG_ADDR_WIDTH = 5;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

	// Major opcode, instruction bits 30 to 25.
	typedef enum logic [5:0] {
		op_other = 6'b000000,
		ty_j     = 6'b100100,
		op_jr    = 6'b100101,
		ty_b     = 6'b100110
	} opcode_t;

	// Conditional branch flavour, bit 14 of a type-B word.
	typedef enum logic {
		beq = 1'b0,
		bne = 1'b1
	} sub_b_t;

	// Jump flavour, bit 24 of a type-J word.
	typedef enum logic {
		j   = 1'b0,
		jal = 1'b1
	} sub_j_t;

	// Instruction field positions.
	localparam int OPCODE_HI = 30;
	localparam int OPCODE_LO = 25;
	localparam int RT_HI     = 24;
	localparam int RT_LO     = 20;
	localparam int RA_HI     = 19;
	localparam int RA_LO     = 15;
	localparam int RB_HI     = 14;
	localparam int RB_LO     = 10;
	localparam int IMM14_HI  = 13;
	localparam int IMM14_LO  = 0;
	localparam int IMM24_HI  = 23;
	localparam int IMM24_LO  = 0;
	localparam int SUB_B_BIT = 14;
	localparam int SUB_J_BIT = 24;

	// Return address register written by JAL.
	localparam logic [4:0] link_reg = 5'd30;

endpackage
